//--- design/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_op_t;

    // ALU_NOP must stay zero so that an all-zero bundle is a bubble.
    localparam alu_op_t ALU_NOP = 4'd0;
    localparam alu_op_t ALU_ADD = 4'd1;
    localparam alu_op_t ALU_SUB = 4'd2;
    localparam alu_op_t ALU_AND = 4'd3;
    localparam alu_op_t ALU_OR  = 4'd4;
    localparam alu_op_t ALU_XOR = 4'd5;
    localparam alu_op_t ALU_SLT = 4'd6;
    localparam alu_op_t ALU_SLL = 4'd7;
    localparam alu_op_t ALU_SRL = 4'd8;
    localparam alu_op_t ALU_LUI = 4'd9;
    localparam alu_op_t ALU_BEQ = 4'd10;
    localparam alu_op_t ALU_BNE = 4'd11;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    localparam data_t     ZERO_WORD = 32'h0000_0000;
    localparam reg_addr_t ZERO_REG  = 5'd0;

    typedef struct packed {
        addr_t     pc;
        alu_op_t   aluop;
        data_t     opr1;
        data_t     opr2;
        data_t     offset;     // the branch offset is sign-extended and already times four.
        reg_addr_t wraddr;
        logic      wreg;
    } id_ex_t;

    localparam id_ex_t ID_EX_BUBBLE = '{
        pc:     ZERO_WORD,
        aluop:  ALU_NOP,
        opr1:   ZERO_WORD,
        opr2:   ZERO_WORD,
        offset: ZERO_WORD,
        wraddr: ZERO_REG,
        wreg:   1'b0
    };

endpackage

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,
    input  logic              rst,
    input  logic              we,
    input  mips_pkg::reg_addr_t waddr,
    input  mips_pkg::data_t     wdata,
    input  mips_pkg::reg_addr_t raddr1,
    input  mips_pkg::reg_addr_t raddr2,
    output mips_pkg::data_t     rdata1,
    output mips_pkg::data_t     rdata2
);
    import mips_pkg::*;

    // register zero has no storage at all.
    data_t regs [1:31];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= ZERO_WORD;
            end
        end
        else if (we && (waddr != ZERO_REG)) begin
            regs[waddr] <= wdata;
        end
    end

    // reads see the old value during a write cycle.
    always_comb begin
        if (raddr1 == ZERO_REG) begin
            rdata1 = ZERO_WORD;
        end
        else begin
            rdata1 = regs[raddr1];
        end
        if (raddr2 == ZERO_REG) begin
            rdata2 = ZERO_WORD;
        end
        else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

//--- design/id_decode.sv
`timescale 1ns/1ps

module id_decode (
    input  mips_pkg::addr_t     pc,
    input  mips_pkg::data_t     instr,
    input  logic                instr_valid,
    input  mips_pkg::data_t     rdata1,
    input  mips_pkg::data_t     rdata2,
    input  logic                ex_wreg,
    input  mips_pkg::reg_addr_t ex_wraddr,
    input  mips_pkg::data_t     ex_result,
    output mips_pkg::reg_addr_t raddr1,
    output mips_pkg::reg_addr_t raddr2,
    output mips_pkg::id_ex_t    id_bundle
);
    import mips_pkg::*;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [4:0]  shamt;
    logic [15:0] imm;
    data_t       imm_sext;
    data_t       imm_zext;
    data_t       rs_val;
    data_t       rt_val;
    logic        fwd_rs;
    logic        fwd_rt;
    logic        known;
    id_ex_t      dec;

    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = instr[5:0];
    assign imm    = instr[15:0];

    assign imm_sext = {{16{imm[15]}}, imm};
    assign imm_zext = {16'h0000, imm};

    assign raddr1 = rs;
    assign raddr2 = rt;

    // the register file is written only at the end of execute, so the
    // instruction now in execute has to be bypassed here.
    assign fwd_rs = ex_wreg && (ex_wraddr == rs) && (rs != ZERO_REG);
    assign fwd_rt = ex_wreg && (ex_wraddr == rt) && (rt != ZERO_REG);
    assign rs_val = fwd_rs ? ex_result : rdata1;
    assign rt_val = fwd_rt ? ex_result : rdata2;

    always_comb begin
        known       = 1'b1;
        dec.pc      = pc;
        dec.aluop   = ALU_NOP;
        dec.opr1    = rs_val;
        dec.opr2    = rt_val;
        dec.offset  = {imm_sext[29:0], 2'b00};
        dec.wraddr  = rt;
        dec.wreg    = 1'b1;
        case (opcode)
            OP_SPECIAL: begin
                dec.wraddr = rd;
                case (funct)
                    FN_ADDU: dec.aluop = ALU_ADD;
                    FN_SUBU: dec.aluop = ALU_SUB;
                    FN_AND:  dec.aluop = ALU_AND;
                    FN_OR:   dec.aluop = ALU_OR;
                    FN_XOR:  dec.aluop = ALU_XOR;
                    FN_SLT:  dec.aluop = ALU_SLT;
                    FN_SLL, FN_SRL: begin
                        // shifts take rt as the value and shamt as the amount.
                        dec.aluop = (funct == FN_SLL) ? ALU_SLL : ALU_SRL;
                        dec.opr1  = rt_val;
                        dec.opr2  = {27'd0, shamt};
                    end
                    default: known = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                dec.aluop = ALU_ADD;
                dec.opr2  = imm_sext;
            end
            OP_ANDI: begin
                dec.aluop = ALU_AND;
                dec.opr2  = imm_zext;
            end
            OP_ORI: begin
                dec.aluop = ALU_OR;
                dec.opr2  = imm_zext;
            end
            OP_LUI: begin
                dec.aluop = ALU_LUI; // the ALU moves the immediate up.
                dec.opr2  = imm_zext;
            end
            OP_BEQ, OP_BNE: begin
                dec.aluop  = (opcode == OP_BEQ) ? ALU_BEQ : ALU_BNE;
                dec.wraddr = ZERO_REG;
                dec.wreg   = 1'b0;
            end
            default: known = 1'b0;
        endcase
    end

    assign id_bundle = (instr_valid && known) ? dec : ID_EX_BUBBLE;

endmodule

//--- design/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  logic             flush,
    input  mips_pkg::id_ex_t id_bundle,
    output mips_pkg::id_ex_t ex_bundle
);
    import mips_pkg::*;

    // flush beats stall, so a taken branch always squashes the next slot.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_bundle <= ID_EX_BUBBLE;
        end
        else begin
            case ({flush, stall})
                2'b10, 2'b11: begin
                    ex_bundle <= ID_EX_BUBBLE;
                end
                2'b00: begin
                    ex_bundle <= id_bundle;
                end
                default: begin
                    ex_bundle <= ex_bundle; // the stalled instruction stays.
                end
            endcase
        end
    end

endmodule

//--- design/ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
    input  mips_pkg::id_ex_t ex_bundle,
    output mips_pkg::data_t  result,
    output logic             take_branch,
    output mips_pkg::addr_t  target
);
    import mips_pkg::*;

    data_t      opr1;
    data_t      opr2;
    logic [4:0] sa;
    logic       slt_lt;
    logic       equal;

    assign opr1 = ex_bundle.opr1;
    assign opr2 = ex_bundle.opr2;
    assign sa   = opr2[4:0];

    assign slt_lt = $signed(opr1) < $signed(opr2);
    assign equal  = (opr1 == opr2);

    always_comb begin
        case (ex_bundle.aluop)
            ALU_ADD: begin
                result = opr1 + opr2; // the sum wraps without an overflow trap.
            end
            ALU_SUB: begin
                result = opr1 - opr2;
            end
            ALU_AND: begin
                result = opr1 & opr2;
            end
            ALU_OR: begin
                result = opr1 | opr2;
            end
            ALU_XOR: begin
                result = opr1 ^ opr2;
            end
            ALU_SLT: begin
                result = {31'd0, slt_lt};
            end
            ALU_SLL: begin
                result = opr1 << sa;
            end
            ALU_SRL: begin
                result = opr1 >> sa;
            end
            ALU_LUI: begin
                result = opr2 << 16;
            end
            default: begin
                // branches and bubbles write nothing.
                result = ZERO_WORD;
            end
        endcase
    end

    always_comb begin
        case (ex_bundle.aluop)
            ALU_BEQ: take_branch = equal;
            ALU_BNE: take_branch = !equal;
            default: take_branch = 1'b0;
        endcase
    end

    // no delay slot, so the target is relative to the branch itself plus four.
    assign target = ex_bundle.pc + 32'd4 + ex_bundle.offset;

endmodule

//--- design/mips_exec_core.sv
`timescale 1ns/1ps

module mips_exec_core (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  logic                instr_valid,
    input  mips_pkg::addr_t     pc,
    input  mips_pkg::data_t     instr,
    output logic                wb_valid,
    output mips_pkg::reg_addr_t wb_addr,
    output mips_pkg::data_t     wb_data,
    output logic                redirect,
    output mips_pkg::addr_t     redirect_pc
);
    import mips_pkg::*;

    reg_addr_t raddr1;
    reg_addr_t raddr2;
    data_t     rdata1;
    data_t     rdata2;
    id_ex_t    id_bundle;
    id_ex_t    ex_bundle;
    data_t     result;
    logic      take_branch;
    addr_t     target;
    logic      flush;

    reg_file i_reg_file (
        .clk    (clk),
        .rst    (rst),
        .we     (wb_valid),
        .waddr  (wb_addr),
        .wdata  (wb_data),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    id_decode i_id_decode (
        .pc          (pc),
        .instr       (instr),
        .instr_valid (instr_valid),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .ex_wreg     (ex_bundle.wreg),
        .ex_wraddr   (ex_bundle.wraddr),
        .ex_result   (result),
        .raddr1      (raddr1),
        .raddr2      (raddr2),
        .id_bundle   (id_bundle)
    );

    id_ex_reg i_id_ex_reg (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .flush     (flush),
        .id_bundle (id_bundle),
        .ex_bundle (ex_bundle)
    );

    ex_alu i_ex_alu (
        .ex_bundle   (ex_bundle),
        .result      (result),
        .take_branch (take_branch),
        .target      (target)
    );

    // a stalled execute slot stays put, so its write and redirect wait too.
    assign wb_valid = ex_bundle.wreg && !stall;
    assign wb_addr  = ex_bundle.wraddr;
    assign wb_data  = result;

    assign redirect    = take_branch && !stall;
    assign redirect_pc = target;

    // the word in decode during a redirect is on the wrong path.
    assign flush = redirect;

endmodule

//--- bench/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// kinds of event that one accepted instruction leaves for the execute cycle.
localparam logic [1:0] EV_NONE     = 2'd0;
localparam logic [1:0] EV_WB       = 2'd1;
localparam logic [1:0] EV_ZERO_WB  = 2'd2; // a write to r0 may or may not strobe.
localparam logic [1:0] EV_REDIRECT = 2'd3;

typedef struct packed {
    logic [1:0] kind;
    reg_addr_t  addr;
    data_t      data;
    addr_t      target;
} exp_event_t;

data_t      model_regs [32];
exp_event_t expected_q [$];

function automatic data_t model_read(input reg_addr_t r);
    return (r == 5'd0) ? 32'd0 : model_regs[r];
endfunction

// applies one instruction to the architectural state in program order.
function automatic exp_event_t model_execute(input addr_t ipc, input data_t iw);
    logic [15:0] imm;
    data_t       a;
    data_t       b;
    data_t       res;
    reg_addr_t   dst;
    logic        writes;
    exp_event_t  ev;
    imm    = iw[15:0];
    a      = model_read(iw[25:21]);
    b      = model_read(iw[20:16]);
    dst    = iw[20:16];
    res    = 32'd0;
    writes = 1'b1;
    ev     = '0;
    case (iw[31:26])
        OP_SPECIAL: begin
            dst = iw[15:11];
            case (iw[5:0])
                FN_ADDU: res = a + b;
                FN_SUBU: res = a - b;
                FN_AND:  res = a & b;
                FN_OR:   res = a | b;
                FN_XOR:  res = a ^ b;
                FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                FN_SLL:  res = b << iw[10:6];
                FN_SRL:  res = b >> iw[10:6];
                default: writes = 1'b0;
            endcase
        end
        OP_ADDIU: res = a + {{16{imm[15]}}, imm};
        OP_ANDI:  res = a & {16'h0000, imm};
        OP_ORI:   res = a | {16'h0000, imm};
        OP_LUI:   res = {imm, 16'h0000};
        OP_BEQ, OP_BNE: begin
            writes = 1'b0;
            if ((a == b) == (iw[31:26] == OP_BEQ)) begin
                ev.kind   = EV_REDIRECT;
                ev.target = ipc + 32'd4 + {{14{imm[15]}}, imm, 2'b00};
            end
        end
        default: writes = 1'b0;
    endcase
    if (writes && dst == 5'd0) begin
        ev.kind = EV_ZERO_WB;
    end
    else if (writes) begin
        model_regs[dst] = res;
        ev.kind         = EV_WB;
        ev.addr         = dst;
        ev.data         = res;
    end
    return ev;
endfunction

`endif

//--- bench/tb_mips_exec_core.sv
`timescale 1ns/1ps

module tb_mips_exec_core;
    import mips_pkg::*;

    `include "tb_ref_model.svh"

    localparam int NUM_INSTR    = 3000;
    localparam int DRAIN_CYCLES = 4;

    logic      clk;
    logic      rst;
    logic      stall;
    logic      instr_valid;
    addr_t     pc;
    data_t     instr;
    logic      wb_valid;
    reg_addr_t wb_addr;
    data_t     wb_data;
    logic      redirect;
    addr_t     redirect_pc;

    logic [31:0] lfsr_state;
    addr_t       next_pc;

    mips_exec_core i_dut (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .instr_valid (instr_valid),
        .pc          (pc),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // about one clock per instruction is needed and four leave ample margin.
    initial begin
        #(NUM_INSTR * 8 * 4);
        fail_run("watchdog expired before the run finished");
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "run stopped");
    endtask

    // taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] bits;
        bits = 32'd0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits       = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // registers come from r0..r7 so that neighbours often depend on each other.
    function automatic data_t random_instr();
        logic [31:0] pick;
        logic [31:0] rs;
        logic [31:0] rt;
        logic [31:0] rd;
        logic [31:0] low;
        pick = random_bits(4);
        rs   = random_bits(3);
        rt   = random_bits(3);
        rd   = random_bits(3);
        low  = random_bits(16);
        case (pick[3:0])
            4'd0:  return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, FN_ADDU};
            4'd1:  return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, FN_SUBU};
            4'd2:  return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, FN_AND};
            4'd3:  return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, FN_OR};
            4'd4:  return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, FN_XOR};
            4'd5:  return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, FN_SLT};
            4'd6:  return {OP_SPECIAL, 5'd0, rt[4:0], rd[4:0], low[4:0], FN_SLL};
            4'd7:  return {OP_SPECIAL, 5'd0, rt[4:0], rd[4:0], low[4:0], FN_SRL};
            4'd9:  return {OP_ANDI, rs[4:0], rt[4:0], low[15:0]};
            4'd10: return {OP_ORI, rs[4:0], rt[4:0], low[15:0]};
            4'd11: return {OP_LUI, 5'd0, rt[4:0], low[15:0]};
            4'd12, 4'd13: return {OP_BEQ, rs[4:0], rt[4:0], low[15:0]};
            4'd14: return {OP_BNE, rs[4:0], rt[4:0], low[15:0]};
            default: return {OP_ADDIU, rs[4:0], rt[4:0], low[15:0]};
        endcase
    endfunction

    task automatic check_wb(input reg_addr_t exp_addr, input data_t exp_data);
        if (wb_valid !== 1'b1) begin
            fail_run($sformatf("no register write at %0t although r%0d = %h was due",
                               $time, exp_addr, exp_data));
        end
        else if (wb_addr !== exp_addr || wb_data !== exp_data) begin
            fail_run($sformatf("** Error at time %0t: write r%0d = %h, expected r%0d = %h",
                               $time, wb_addr, wb_data, exp_addr, exp_data));
        end
    endtask

    task automatic check_redirect(input addr_t exp_pc);
        if (redirect !== 1'b1) begin
            fail_run($sformatf("no redirect at %0t although a branch to %h was taken",
                               $time, exp_pc));
        end
        else if (redirect_pc !== exp_pc) begin
            fail_run($sformatf("** Error at time %0t: redirect to %h, expected %h",
                               $time, redirect_pc, exp_pc));
        end
    endtask

    task automatic expect_no_wb(input logic zero_ok);
        if (wb_valid !== 1'b0 && !(zero_ok && wb_addr === ZERO_REG)) begin
            fail_run($sformatf("unexpected register write to r%0d at %0t", wb_addr, $time));
        end
    endtask

    task automatic expect_no_redirect();
        if (redirect !== 1'b0) begin
            fail_run($sformatf("unexpected redirect to %h at %0t", redirect_pc, $time));
        end
    endtask

    task automatic compare_cycle(output logic squash, output addr_t jump_pc);
        exp_event_t ev;
        ev      = '0;
        squash  = 1'b0;
        jump_pc = 32'd0;
        // a stalled execute slot keeps its event for a later cycle.
        if (!stall && expected_q.size() != 0) begin
            ev = expected_q.pop_front();
        end
        case (ev.kind)
            EV_WB: begin
                check_wb(ev.addr, ev.data);
                expect_no_redirect();
            end
            EV_REDIRECT: begin
                check_redirect(ev.target);
                expect_no_wb(1'b0);
                squash  = 1'b1;
                jump_pc = ev.target;
            end
            EV_ZERO_WB: begin
                expect_no_wb(1'b1);
                expect_no_redirect();
            end
            EV_NONE: begin
                expect_no_wb(1'b0);
                expect_no_redirect();
            end
        endcase
    endtask

    task automatic present_next();
        instr_valid = (random_bits(3) != 32'd0);
        pc          = next_pc;
        instr       = random_instr();
        if (instr_valid) begin
            next_pc = next_pc + 32'd4;
        end
    endtask

    // starts and ends on a falling edge, checks just before the rising one.
    task automatic run_cycle(input logic draining);
        logic  squash;
        addr_t jump_pc;
        if (!stall) begin
            if (draining) begin
                instr_valid = 1'b0;
            end
            else begin
                present_next();
            end
        end
        stall = draining ? 1'b0 : (random_bits(3) == 32'd0);
        #3;
        compare_cycle(squash, jump_pc);
        if (squash) begin
            next_pc = jump_pc;
        end
        if (!stall && !squash && instr_valid) begin
            expected_q.push_back(model_execute(pc, instr));
        end
        @(negedge clk);
    endtask

    initial begin
        lfsr_state  = 32'hccf0c56c;
        rst         = 1'b1;
        stall       = 1'b0;
        instr_valid = 1'b0;
        pc          = 32'd0;
        instr       = 32'd0;
        next_pc     = 32'h0040_0000;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = 32'd0;
        end
        repeat (2) begin
            #3;
            if (wb_valid !== 1'b0 || redirect !== 1'b0) begin
                fail_run("a write or redirect strobe was active during reset");
            end
            @(negedge clk);
        end
        rst = 1'b0;
        for (int n = 0; n < NUM_INSTR; n++) begin
            run_cycle(1'b0);
        end
        repeat (DRAIN_CYCLES) begin
            run_cycle(1'b1);
        end
        if (expected_q.size() == 0) begin
            $display("Test passed");
            $finish;
        end
        else begin
            fail_run("an expected write or redirect never appeared");
        end
    end

endmodule

//--- mips_exec_core.f
+incdir+bench
design/mips_pkg.sv
design/reg_file.sv
design/id_decode.sv
design/id_ex_reg.sv
design/ex_alu.sv
design/mips_exec_core.sv
bench/tb_mips_exec_core.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps \
        --top-module tb_mips_exec_core \
        -f mips_exec_core.f \
        -Mdir obj_dir -o sim_tb; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/sim_tb; then
    echo "simulation reported a failure"
    exit 1
fi

exit 0
